// ==== Makefile ====
# Verilator build and run for the execution unit testbench.

VERILATOR ?= verilator
TOP       ?= executionUnitTb
FILELIST  ?= execUnit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_TEXT ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
	  echo "Simulation passed."; \
	else \
	  echo "Simulation did not pass, see $(LOG)."; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/executionUnitTb.sv ====
`timescale 1ns/1ns

module executionUnitTb;
  import euOpsPkg::*;
  import euRegMapPkg::*;

  localparam int dataWidth = 16;
  localparam int randRows = 24;

  typedef struct packed {
    logic [31:0] ax, ay, mx, my, si, se, astat, cmd;
    logic [apbAddrWidth-1:0] addr;  // Result register to read.
    logic [31:0] expVal, expAstat;
    logic expErr;
  } stimRow;

  logic DSPCLK, rst, psel, penable, pwrite, pready, pslverr;
  logic [apbAddrWidth-1:0] paddr;
  logic [31:0] pwdata, prdata;

  stimRow rows[$];
  logic [31:0] lfsrState = 32'hab84_0ce3;
  int cycleCount = 0;
  int cycleLimit = 100000;
  int waitCycles = 0;  // Access cycles before pready in the last transfer.

  executionUnit #(.dataWidth(dataWidth)) dut0 (
    .DSPCLK(DSPCLK), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial begin
    DSPCLK = 1'b0;
    forever #20 DSPCLK = ~DSPCLK;
  end

  always @(posedge DSPCLK) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: test did not finish within %0d clock cycles", cycleLimit);
      $display(">>> FAIL");
      $fatal(1, "Run timed out.");
    end
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    if (s[0]) lfsrNext = (s >> 1) ^ 32'ha300_0000;  // Galois taps 32, 30, 26, 25.
    else lfsrNext = s >> 1;
  endfunction

  function automatic logic [31:0] cmdWord(input euCond c, input euOp o);
    cmdWord = {24'd0, c, o};
  endfunction

  // Access cycles before pready for a CMD write, from the timing rules.
  function automatic int cmdWaits(input logic [7:0] cmd, input logic [5:0] flags,
                                  input logic err);
    logic hold;
    case (euCond'(cmd[7:4]))
      cdEq: hold = flags[0];
      cdNe: hold = !flags[0];
      cdLt: hold = flags[1] ^ flags[2];
      cdGe: hold = !(flags[1] ^ flags[2]);
      cdAv: hold = flags[2];
      cdNotAv: hold = !flags[2];
      cdAc: hold = flags[3];
      cdMv: hold = flags[4];
      cdSs: hold = flags[5];
      default: hold = 1'b1;
    endcase
    if (err) cmdWaits = 0;
    else if (hold && (cmd[3:0] inside {opMul, opMac, opMsub})) cmdWaits = 2;
    else cmdWaits = 1;
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  // Reference ALU for add and subtract, flags returned as AC, AV, AN, AZ.
  task automatic aluModel(input logic isSub, input logic [15:0] a, input logic [15:0] b,
                          output logic [15:0] res, output logic [3:0] flags);
    int ua, ub, sa, sb, raw, sres;
    ua = 32'(a);
    ub = 32'(b);
    sa = int'($signed(a));
    sb = int'($signed(b));
    if (isSub) begin
      raw = ua + (ub ^ 'hffff) + 1;  // Carry of a plus not b plus one.
      sres = sa - sb;
    end else begin
      raw = ua + ub;
      sres = sa + sb;
    end
    res = raw[15:0];
    flags = {raw > 'hffff, (sres > 32767) || (sres < -32768), res[15], res == '0};
  endtask

  task automatic checkValue(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Value mismatch.");
    end
  endtask

  task automatic apbXfer(input logic write, input logic [apbAddrWidth-1:0] addr,
                         input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
    logic done;
    @(negedge DSPCLK);
    psel = 1'b1;  // Setup phase.
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge DSPCLK);
    penable = 1'b1;
    done = 1'b0;
    waitCycles = 0;
    while (!done) begin
      #10;  // Middle of the low phase.
      if (pready) begin
        rdata = prdata;
        err = pslverr;
        done = 1'b1;
      end else begin
        waitCycles = waitCycles + 1;
      end
      @(negedge DSPCLK);
    end
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apbWrite(input logic [apbAddrWidth-1:0] addr, input logic [31:0] data,
                          output logic err);
    logic [31:0] unused;
    apbXfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apbRead(input logic [apbAddrWidth-1:0] addr, output logic [31:0] data,
                         output logic err);
    apbXfer(1'b0, addr, '0, data, err);
  endtask

  task automatic writeOk(input logic [apbAddrWidth-1:0] addr, input logic [31:0] data);
    logic err;
    apbWrite(addr, data, err);
    checkValue($sformatf("pslverr on write to %0h", addr), 32'(err), 0);
    checkValue($sformatf("wait states on write to %0h", addr), 32'(waitCycles), 0);
  endtask

  task automatic addRow(input logic [31:0] ax, ay, mx, my, si, se, astat, cmd,
                        input logic [apbAddrWidth-1:0] addr,
                        input logic [31:0] expVal, expAstat, input logic expErr);
    rows.push_back('{ax, ay, mx, my, si, se, astat, cmd, addr, expVal, expAstat, expErr});
  endtask

  task automatic buildTable();
    logic [31:0] op, a, b;
    logic [15:0] res;
    logic [3:0] flags;
    // ALU corners.
    addRow('h7fff, 1, 0, 0, 0, 0, 0, cmdWord(cdAlways, opAdd), regAr, 'h8000, 'h06, 1'b0);
    addRow(0, 1, 0, 0, 0, 0, 0, cmdWord(cdAlways, opSub), regAr, 'hffff, 'h02, 1'b0);
    addRow('hffff, 1, 0, 0, 0, 0, 0, cmdWord(cdAlways, opAdd), regAr, 0, 'h09, 1'b0);
    addRow('h8000, 1, 0, 0, 0, 0, 0, cmdWord(cdAlways, opSub), regAr, 'h7fff, 'h0c, 1'b0);
    addRow(5, 5, 0, 0, 0, 0, 0, cmdWord(cdAlways, opSub), regAr, 0, 'h09, 1'b0);
    addRow('hf0f0, 'h3c3c, 0, 0, 0, 0, 'h3c, cmdWord(cdAlways, opAnd), regAr, 'h3030, 'h30, 1'b0);
    addRow('h8000, 1, 0, 0, 0, 0, 0, cmdWord(cdAlways, opOr), regAr, 'h8001, 'h02, 1'b0);
    addRow('haaaa, 'haaaa, 0, 0, 0, 0, 0, cmdWord(cdAlways, opXor), regAr, 0, 'h01, 1'b0);
    addRow('h1234, 0, 0, 0, 0, 0, 'h0f, cmdWord(cdAlways, opPassX), regAr, 'h1234, 0, 1'b0);
    // MAC, MR carries over from row to row.
    addRow(0, 0, 3, 'hfffe, 0, 0, 0, cmdWord(cdAlways, opMul), regMr0, 'hfffa, 0, 1'b0);
    addRow(0, 0, 4, 5, 0, 0, 0, cmdWord(cdAlways, opMac), regMr0, 'h000e, 0, 1'b0);
    addRow(0, 0, 'h100, 'h100, 0, 0, 0, cmdWord(cdAlways, opMsub), regMr1, 'hffff, 0, 1'b0);
    addRow(0, 0, 7, 7, 0, 0, 0, cmdWord(cdEq, opMac), regMr2, 'h00ff, 0, 1'b0);
    addRow(0, 0, 'h8000, 'h8000, 0, 0, 0, cmdWord(cdAlways, opMul), regMr1, 'h4000, 0, 1'b0);
    addRow(0, 0, 'h8000, 'h8000, 0, 0, 0, cmdWord(cdAlways, opMac), regMr1, 'h8000, 'h10, 1'b0);
    addRow(0, 0, 'h8000, 'h8000, 0, 0, 0, cmdWord(cdAlways, opMac), regMr2, 0, 'h10, 1'b0);
    // Shifter, SE is signed.
    addRow(0, 0, 0, 0, 'h8001, 4, 0, cmdWord(cdAlways, opLsh), regSr0, 'h0010, 'h20, 1'b0);
    addRow(0, 0, 0, 0, 'h8001, 4, 0, cmdWord(cdAlways, opAsh), regSr1, 'hfff8, 'h20, 1'b0);
    addRow(0, 0, 0, 0, 'h8000, 'hfc, 0, cmdWord(cdAlways, opAsh), regSr0, 'hf800, 'h20, 1'b0);
    addRow(0, 0, 0, 0, 'h8000, 'hfc, 0, cmdWord(cdAlways, opLsh), regSr0, 'h0800, 'h20, 1'b0);
    addRow(0, 0, 0, 0, 'h1234, 'h28, 'h20, cmdWord(cdAlways, opLsh), regSr0, 0, 0, 1'b0);
    addRow(0, 0, 0, 0, 'h8000, 'hd8, 0, cmdWord(cdAlways, opAsh), regSr1, 'hffff, 'h20, 1'b0);
    // Conditions, true and false.
    addRow(2, 3, 0, 0, 0, 0, 'h01, cmdWord(cdEq, opAdd), regAr, 5, 0, 1'b0);
    addRow(7, 7, 0, 0, 0, 0, 0, cmdWord(cdEq, opAdd), regAr, 5, 0, 1'b0);
    addRow(1, 2, 0, 0, 0, 0, 'h02, cmdWord(cdLt, opSub), regAr, 'hffff, 'h02, 1'b0);
    addRow(1, 1, 0, 0, 0, 0, 'h04, cmdWord(cdNotAv, opAdd), regAr, 'hffff, 'h04, 1'b0);
    addRow(0, 0, 0, 0, 'h00ff, 1, 0, cmdWord(cdSs, opLsh), regSr0, 'hffff, 0, 1'b0);
    addRow('h42, 0, 0, 0, 0, 0, 'h08, cmdWord(cdAc, opPassX), regAr, 'h42, 0, 1'b0);
    addRow(0, 0, 2, 3, 0, 0, 'h10, cmdWord(cdMv, opMul), regMr0, 6, 0, 1'b0);
    // Illegal opcode and illegal condition.
    addRow(9, 9, 0, 0, 0, 0, 'h05, 'hf6, regAr, 'h42, 'h05, 1'b1);
    addRow(9, 9, 0, 0, 0, 0, 0, 'ha0, regAr, 'h42, 0, 1'b1);
    for (int i = 0; i < randRows; i++) begin
      takeBits(1, op);
      takeBits(16, a);
      takeBits(16, b);
      aluModel(op[0], a[15:0], b[15:0], res, flags);
      addRow(a, b, 0, 0, 0, 0, 'h30, op[0] ? cmdWord(cdAlways, opSub) : cmdWord(cdAlways, opAdd),
             regAr, 32'(res), {26'd0, 2'b11, flags}, 1'b0);
    end
  endtask

  task automatic applyRow(input int idx, input stimRow r);
    logic [31:0] data;
    logic err;
    writeOk(regAx, r.ax);
    writeOk(regAy, r.ay);
    writeOk(regMx, r.mx);
    writeOk(regMy, r.my);
    writeOk(regSi, r.si);
    writeOk(regSe, r.se);
    writeOk(regAstat, r.astat);
    apbWrite(regCmd, r.cmd, err);
    checkValue($sformatf("row %0d CMD pslverr", idx), 32'(err), 32'(r.expErr));
    checkValue($sformatf("row %0d CMD wait states", idx), 32'(waitCycles),
               32'(cmdWaits(r.cmd[7:0], r.astat[5:0], r.expErr)));
    apbRead(r.addr, data, err);
    checkValue($sformatf("row %0d result at %0h", idx, r.addr), data, r.expVal);
    apbRead(regAstat, data, err);
    checkValue($sformatf("row %0d ASTAT", idx), data, r.expAstat);
  endtask

  initial begin
    logic [31:0] data;
    logic err;
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    buildTable();
    cycleLimit = (rows.size() * 10 + 20) * 8 + 50;  // Ten transfers per row.
    repeat (4) @(posedge DSPCLK);
    @(negedge DSPCLK);
    rst = 1'b0;
    apbRead(regAr, data, err);
    checkValue("AR after reset", data, 0);
    apbRead(regAstat, data, err);
    checkValue("ASTAT after reset", data, 0);
    for (int i = 0; i < rows.size(); i++) applyRow(i, rows[i]);
    apbWrite(regCmd, 'hf6, err);
    checkValue("pslverr on illegal CMD", 32'(err), 1);
    apbRead(regCmd, data, err);
    checkValue("CMD readback", data, rows[$].cmd);
    apbWrite(regAr, 'h1111, err);
    checkValue("pslverr on AR write", 32'(err), 1);
    apbRead(regAr, data, err);
    checkValue("AR after rejected write", data, rows[$].expVal);
    apbWrite(regMr0, 'h2222, err);
    checkValue("pslverr on MR0 write", 32'(err), 1);
    apbRead(regMr0, data, err);
    checkValue("MR0 after rejected write", data, 6);
    apbWrite(6'h38, 'h3333, err);
    checkValue("pslverr on unmapped write", 32'(err), 1);
    apbRead(6'h38, data, err);
    checkValue("pslverr on unmapped read", 32'(err), 1);
    writeOk(regAstat, 'h2a);
    apbRead(regAstat, data, err);
    checkValue("ASTAT direct write", data, 'h2a);
    writeOk(regAx, 'h0001_abcd);
    apbRead(regAx, data, err);
    checkValue("AX upper bits", data, 'habcd);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== execUnit.f ====
source/euOpsPkg.sv
source/euRegMapPkg.sv
source/euAlu.sv
source/euMac.sv
source/euShifter.sv
source/euControl.sv
source/executionUnit.sv
bench/executionUnitTb.sv

// ==== source/euAlu.sv ====
`timescale 1ns/1ns

module euAlu #(
  parameter int dataWidth = 16
) (
  input  logic                 DSPCLK,
  input  logic                 rst,
  input  logic                 aluStart,
  input  euOpsPkg::euOp        opcode,
  input  logic [dataWidth-1:0] ax,
  input  logic [dataWidth-1:0] ay,
  output logic [dataWidth-1:0] ar,
  output logic                 aluDone,
  output logic                 az,
  output logic                 an,
  output logic                 av,
  output logic                 ac
);
  import euOpsPkg::*;

  localparam int msb = dataWidth - 1;

  logic [dataWidth:0] sum;  // Carry in top bit.
  logic [dataWidth-1:0] result;
  logic carry, ovf;

  always_comb begin
    sum = '0;
    result = ax;
    carry = 1'b0;
    ovf = 1'b0;
    case (opcode)
      opAdd: begin
        sum = {1'b0, ax} + {1'b0, ay};
        result = sum[msb:0];
        carry = sum[dataWidth];
        ovf = (ax[msb] == ay[msb]) && (result[msb] != ax[msb]);
      end
      opSub: begin
        sum = {1'b0, ax} + {1'b0, ~ay} + 1'b1;  // Carry means no borrow.
        result = sum[msb:0];
        carry = sum[dataWidth];
        ovf = (ax[msb] != ay[msb]) && (result[msb] != ax[msb]);
      end
      opAnd: result = ax & ay;
      opOr: result = ax | ay;
      opXor: result = ax ^ ay;
      default: result = ax;  // Pass X.
    endcase
  end

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      ar <= '0;
      aluDone <= 1'b0;
      az <= 1'b0;
      an <= 1'b0;
      av <= 1'b0;
      ac <= 1'b0;
    end else begin
      aluDone <= aluStart;
      if (aluStart) begin
        ar <= result;
        az <= (result == '0);
        an <= result[msb];
        av <= ovf;
        ac <= carry;
      end
    end
  end

  aluOpOnly: assert property (@(posedge DSPCLK) disable iff (rst)
    aluStart |-> (opcode inside {opAdd, opSub, opAnd, opOr, opXor, opPassX}));

endmodule

// ==== source/euControl.sv ====
`timescale 1ns/1ns

module euControl #(
  parameter int dataWidth = 16
) (
  input  logic                               DSPCLK,
  input  logic                               rst,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [euRegMapPkg::apbAddrWidth-1:0] paddr,
  input  logic [31:0]                        pwdata,
  output logic [31:0]                        prdata,
  output logic                               pready,
  output logic                               pslverr,
  output logic [dataWidth-1:0]               ax,
  output logic [dataWidth-1:0]               ay,
  output logic [dataWidth-1:0]               mx,
  output logic [dataWidth-1:0]               my,
  output logic [dataWidth-1:0]               si,
  output logic [7:0]                         se,
  output euOpsPkg::euOp                      opcode,
  output logic                               aluStart,
  output logic                               macStart,
  output logic                               shiftStart,
  input  logic                               aluDone,
  input  logic                               az,
  input  logic                               an,
  input  logic                               av,
  input  logic                               ac,
  input  logic [dataWidth-1:0]               ar,
  input  logic                               macDone,
  input  logic                               mv,
  input  logic [2*dataWidth+7:0]             mr,
  input  logic                               shiftDone,
  input  logic                               ss,
  input  logic [2*dataWidth-1:0]             sr
);
  import euOpsPkg::*;
  import euRegMapPkg::*;

  ctrlState state;
  logic [astatWidth-1:0] astat;
  logic [7:0] cmdReg;  // Last accepted command.
  euOp cmdOp;
  euCond cmdCond;
  logic idleAccess, cmdWr, wrEn, accErr;
  logic addrMapped, addrReadOnly;
  logic opLegal, condLegal, condTrue;
  logic aluSel, macSel, shiftSel, issue, skip;

  assign cmdOp = euOp'(pwdata[3:0]);
  assign cmdCond = euCond'(pwdata[7:4]);
  assign idleAccess = psel && penable && (state == stIdle);
  assign cmdWr = pwrite && (paddr == regCmd);

  always_comb begin
    addrMapped = 1'b1;
    addrReadOnly = 1'b0;
    case (paddr)
      regAx, regAy, regMx, regMy, regSi, regSe, regAstat, regCmd: addrMapped = 1'b1;
      regAr, regMr0, regMr1, regMr2, regSr0, regSr1: addrReadOnly = 1'b1;
      default: addrMapped = 1'b0;
    endcase
  end

  always_comb begin
    opLegal = 1'b1;
    aluSel = 1'b0;
    macSel = 1'b0;
    shiftSel = 1'b0;
    case (cmdOp)
      opAdd, opSub, opAnd, opOr, opXor, opPassX: aluSel = 1'b1;
      opMul, opMac, opMsub: macSel = 1'b1;
      opLsh, opAsh: shiftSel = 1'b1;
      default: opLegal = 1'b0;
    endcase
  end

  // Condition is tested against ASTAT as it stands before the command.
  always_comb begin
    condLegal = 1'b1;
    case (cmdCond)
      cdEq: condTrue = astat[astatAz];
      cdNe: condTrue = !astat[astatAz];
      cdLt: condTrue = astat[astatAn] ^ astat[astatAv];
      cdGe: condTrue = !(astat[astatAn] ^ astat[astatAv]);
      cdAv: condTrue = astat[astatAv];
      cdNotAv: condTrue = !astat[astatAv];
      cdAc: condTrue = astat[astatAc];
      cdMv: condTrue = astat[astatMv];
      cdSs: condTrue = astat[astatSs];
      cdAlways: condTrue = 1'b1;
      default: begin
        condTrue = 1'b0;
        condLegal = 1'b0;
      end
    endcase
  end

  assign accErr = !addrMapped || (pwrite && addrReadOnly) ||
                  (cmdWr && !(opLegal && condLegal));
  assign wrEn = idleAccess && pwrite && !accErr;
  assign issue = idleAccess && cmdWr && !accErr && condTrue;
  assign skip = idleAccess && cmdWr && !accErr && !condTrue;

  assign aluStart = issue && aluSel;
  assign macStart = issue && macSel;
  assign shiftStart = issue && shiftSel;
  // Held from CMD once the unit is running.
  assign opcode = (state == stIdle) ? cmdOp : euOp'(cmdReg[3:0]);

  always_comb begin
    case (state)
      stIdle: pready = idleAccess && !issue && !skip;
      stSkip: pready = 1'b1;
      default: pready = aluDone || macDone || shiftDone;
    endcase
  end

  assign pslverr = idleAccess && accErr;

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      state <= stIdle;
    end else begin
      case (state)
        stIdle: begin
          if (issue) state <= stWaitUnit;
          else if (skip) state <= stSkip;
        end
        default: if (pready) state <= stIdle;  // Transfer ends.
      endcase
    end
  end

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      ax <= '0;
      ay <= '0;
      mx <= '0;
      my <= '0;
      si <= '0;
      se <= '0;
      astat <= '0;
      cmdReg <= '0;
    end else begin
      if (wrEn) begin
        case (paddr)
          regAx: ax <= pwdata[dataWidth-1:0];
          regAy: ay <= pwdata[dataWidth-1:0];
          regMx: mx <= pwdata[dataWidth-1:0];
          regMy: my <= pwdata[dataWidth-1:0];
          regSi: si <= pwdata[dataWidth-1:0];
          regSe: se <= pwdata[7:0];
          regAstat: astat <= pwdata[astatWidth-1:0];
          regCmd: cmdReg <= pwdata[7:0];  // Kept even when skipped.
          default: ;
        endcase
      end
      if (aluDone) begin
        astat[astatAz] <= az;
        astat[astatAn] <= an;
        astat[astatAv] <= av;
        astat[astatAc] <= ac;
      end
      if (macDone) astat[astatMv] <= mv;
      if (shiftDone) astat[astatSs] <= ss;
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      regAx: prdata = 32'(ax);
      regAy: prdata = 32'(ay);
      regMx: prdata = 32'(mx);
      regMy: prdata = 32'(my);
      regSi: prdata = 32'(si);
      regSe: prdata = 32'(se);
      regAstat: prdata = 32'(astat);
      regCmd: prdata = 32'(cmdReg);
      regAr: prdata = 32'(ar);
      regMr0: prdata = 32'(mr[dataWidth-1:0]);
      regMr1: prdata = 32'(mr[2*dataWidth-1:dataWidth]);
      regMr2: prdata = 32'(mr[2*dataWidth+7:2*dataWidth]);
      regSr0: prdata = 32'(sr[dataWidth-1:0]);
      regSr1: prdata = 32'(sr[2*dataWidth-1:dataWidth]);
      default: prdata = '0;
    endcase
  end

  // The master must hold the access phase while a unit is busy.
  readyInAccess: assert property (@(posedge DSPCLK) disable iff (rst)
    pready |-> (psel && penable));

  // One unit at a time, so no start meets another start or a done.
  oneStart: assert property (@(posedge DSPCLK) disable iff (rst)
    $onehot0({aluStart, macStart, shiftStart, aluDone, macDone, shiftDone}));

endmodule

// ==== source/euMac.sv ====
`timescale 1ns/1ns

module euMac #(
  parameter int dataWidth = 16
) (
  input  logic                   DSPCLK,
  input  logic                   rst,
  input  logic                   macStart,
  input  euOpsPkg::euOp          opcode,
  input  logic [dataWidth-1:0]   mx,
  input  logic [dataWidth-1:0]   my,
  output logic [2*dataWidth+7:0] mr,
  output logic                   macDone,
  output logic                   mv
);
  import euOpsPkg::*;

  localparam int prodWidth = 2 * dataWidth;
  localparam int mrWidth = prodWidth + 8;

  logic signed [prodWidth-1:0] prodQ;  // Stage 1 product.
  euOp opQ;
  logic stage1Valid;
  logic [mrWidth-1:0] prodExt, mrNext;
  logic [8:0] topBits;  // Guard bits and product sign.

  always_ff @(posedge DSPCLK) begin
    if (macStart) begin
      prodQ <= $signed(mx) * $signed(my);
      opQ <= opcode;
    end
  end

  always_comb begin
    prodExt = {{8{prodQ[prodWidth-1]}}, prodQ};
    case (opQ)
      opMac: mrNext = mr + prodExt;
      opMsub: mrNext = mr - prodExt;
      default: mrNext = prodExt;  // Multiply only.
    endcase
    topBits = mrNext[mrWidth-1:prodWidth-1];
  end

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      stage1Valid <= 1'b0;
      mr <= '0;
      macDone <= 1'b0;
      mv <= 1'b0;
    end else begin
      stage1Valid <= macStart;
      macDone <= stage1Valid;
      if (stage1Valid) begin
        mr <= mrNext;
        mv <= !((&topBits) || !(|topBits));  // Guard bits not a sign extension.
      end
    end
  end

  // Control issues one command at a time.
  noOverlap: assert property (@(posedge DSPCLK) disable iff (rst)
    macStart |-> !stage1Valid);

endmodule

// ==== source/euOpsPkg.sv ====
package euOpsPkg;

  // Command opcodes, CMD bits 3:0.
  typedef enum logic [3:0] {
    opAdd   = 4'd0,
    opSub   = 4'd1,
    opAnd   = 4'd2,
    opOr    = 4'd3,
    opXor   = 4'd4,
    opPassX = 4'd5,
    opMul   = 4'd8,
    opMac   = 4'd9,
    opMsub  = 4'd10,
    opLsh   = 4'd12,
    opAsh   = 4'd13
  } euOp;

  // Condition codes, CMD bits 7:4.
  typedef enum logic [3:0] {
    cdEq     = 4'd0,  // AZ.
    cdNe     = 4'd1,  // Not AZ.
    cdLt     = 4'd2,  // AN xor AV.
    cdGe     = 4'd3,
    cdAv     = 4'd4,
    cdNotAv  = 4'd5,
    cdAc     = 4'd6,
    cdMv     = 4'd7,
    cdSs     = 4'd8,
    cdAlways = 4'd15
  } euCond;

  localparam int astatAz    = 0;
  localparam int astatAn    = 1;
  localparam int astatAv    = 2;
  localparam int astatAc    = 3;
  localparam int astatMv    = 4;
  localparam int astatSs    = 5;
  localparam int astatWidth = 6;

  typedef enum logic [1:0] {stIdle, stWaitUnit, stSkip} ctrlState;

endpackage

// ==== source/euRegMapPkg.sv ====
package euRegMapPkg;

  localparam int apbAddrWidth = 6;  // Byte addresses.

  // Operand and status registers.
  localparam logic [apbAddrWidth-1:0] regAx    = 6'h00;
  localparam logic [apbAddrWidth-1:0] regAy    = 6'h04;
  localparam logic [apbAddrWidth-1:0] regMx    = 6'h08;
  localparam logic [apbAddrWidth-1:0] regMy    = 6'h0C;
  localparam logic [apbAddrWidth-1:0] regSi    = 6'h10;
  localparam logic [apbAddrWidth-1:0] regSe    = 6'h14;
  localparam logic [apbAddrWidth-1:0] regAstat = 6'h18;
  localparam logic [apbAddrWidth-1:0] regCmd   = 6'h1C;

  // Result registers, read only.
  localparam logic [apbAddrWidth-1:0] regAr    = 6'h20;
  localparam logic [apbAddrWidth-1:0] regMr0   = 6'h24;
  localparam logic [apbAddrWidth-1:0] regMr1   = 6'h28;
  localparam logic [apbAddrWidth-1:0] regMr2   = 6'h2C;  // Guard bits.
  localparam logic [apbAddrWidth-1:0] regSr0   = 6'h30;
  localparam logic [apbAddrWidth-1:0] regSr1   = 6'h34;

endpackage

// ==== source/euShifter.sv ====
`timescale 1ns/1ns

module euShifter #(
  parameter int dataWidth = 16
) (
  input  logic                   DSPCLK,
  input  logic                   rst,
  input  logic                   shiftStart,
  input  euOpsPkg::euOp          opcode,
  input  logic [dataWidth-1:0]   si,
  input  logic [7:0]             se,
  output logic [2*dataWidth-1:0] sr,
  output logic                   shiftDone,
  output logic                   ss
);
  import euOpsPkg::*;

  localparam int srWidth = 2 * dataWidth;

  logic arith;
  logic [srWidth-1:0] word, shifted;
  logic [7:0] amount;  // Magnitude of SE.

  always_comb begin
    arith = (opcode == opAsh);
    if (arith) word = {{dataWidth{si[dataWidth-1]}}, si};
    else word = {{dataWidth{1'b0}}, si};
    amount = se[7] ? (~se + 8'd1) : se;
    // Oversized shifts leave zeros, or sign bits for the arithmetic case.
    if (!se[7]) shifted = word << amount;
    else if (arith) shifted = $signed(word) >>> amount;
    else shifted = word >> amount;
  end

  always_ff @(posedge DSPCLK) begin
    if (rst) begin
      sr <= '0;
      shiftDone <= 1'b0;
      ss <= 1'b0;
    end else begin
      shiftDone <= shiftStart;
      if (shiftStart) begin
        sr <= shifted;
        ss <= si[dataWidth-1];  // Sign of input.
      end
    end
  end

endmodule

// ==== source/executionUnit.sv ====
`timescale 1ns/1ns

module executionUnit #(
  parameter int dataWidth = 16
) (
  input  logic                                 DSPCLK,
  input  logic                                 rst,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [euRegMapPkg::apbAddrWidth-1:0] paddr,
  input  logic [31:0]                          pwdata,
  output logic [31:0]                          prdata,
  output logic                                 pready,
  output logic                                 pslverr
);
  import euOpsPkg::*;

  logic [dataWidth-1:0] ax, ay, mx, my, si, ar;
  logic [7:0] se;
  euOp opcode;
  logic aluStart, macStart, shiftStart;
  logic aluDone, az, an, av, ac;
  logic macDone, mv;
  logic [2*dataWidth+7:0] mr;  // Product plus guard bits.
  logic shiftDone, ss;
  logic [2*dataWidth-1:0] sr;

  euControl #(.dataWidth(dataWidth)) control (
    .DSPCLK, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .ax, .ay, .mx, .my, .si, .se, .opcode,
    .aluStart, .macStart, .shiftStart,
    .aluDone, .az, .an, .av, .ac, .ar,
    .macDone, .mv, .mr,
    .shiftDone, .ss, .sr
  );

  euAlu #(.dataWidth(dataWidth)) alu (
    .DSPCLK, .rst, .aluStart, .opcode, .ax, .ay,
    .ar, .aluDone, .az, .an, .av, .ac
  );

  euMac #(.dataWidth(dataWidth)) mac (
    .DSPCLK, .rst, .macStart, .opcode, .mx, .my,
    .mr, .macDone, .mv
  );

  euShifter #(.dataWidth(dataWidth)) shifter (
    .DSPCLK, .rst, .shiftStart, .opcode, .si, .se,
    .sr, .shiftDone, .ss
  );

endmodule
